//--- logic/avg_defines.svh
`ifndef AVG_DEFINES_SVH
`define AVG_DEFINES_SVH

// Sample and average width
`define AVG_WIDTH 8

// Longest legal burst
`define AVG_MAX_SAMPLES 255

// Wide enough to count AVG_MAX_SAMPLES
`define AVG_CNT_WIDTH ($clog2(`AVG_MAX_SAMPLES + 1))

// 255 samples of 255 still fit
`define AVG_SUM_WIDTH 16

// Entries in the sample FIFO, power of two
`define AVG_FIFO_DEPTH 16

`endif

//--- logic/avg_types_pkg.sv
`include "avg_defines.svh"

package avg_types_pkg;

   // One input sample, also the width of the average
   typedef logic [`AVG_WIDTH-1:0] sample_t;

   // Samples seen in a burst
   typedef logic [`AVG_CNT_WIDTH-1:0] count_t;

   // Running sum of a burst
   typedef logic [`AVG_SUM_WIDTH-1:0] sum_t;

   // FIFO entry, last marks the final sample of a burst
   typedef struct packed {
      sample_t data;
      logic    last;
   } sample_word_t;

endpackage

//--- logic/avg_ctrl_pkg.sv
package avg_ctrl_pkg;

   typedef enum logic [2:0] {
      IDLE         = 3'd0,
      ACCUMULATING = 3'd1,
      DIVIDING     = 3'd2,
      OFFER        = 3'd3,  // avg_req high
      RELEASE      = 3'd4   // Waiting for ack to drop
   } avg_state_t;

   typedef enum logic [1:0] {
      DIV_IDLE    = 2'd0,
      DIV_ITERATE = 2'd1,
      DIV_DONE    = 2'd2
   } div_state_t;

endpackage

//--- logic/sample_fifo_if.sv
`timescale 1ns/1ps

interface sample_fifo_if;

   // Write side
   avg_types_pkg::sample_word_t wr_word;
   logic                        push;
   logic                        full;

   // Read side, head entry shown while not empty
   avg_types_pkg::sample_word_t rd_word;
   logic                        pop;
   logic                        empty;

   modport writer (
      output wr_word, push,
      input  full
   );

   modport storage (
      input  wr_word, push, pop,
      output full, rd_word, empty
   );

   modport reader (
      output pop,
      input  rd_word, empty
   );

endinterface

//--- logic/sample_capture.sv
`timescale 1ns/1ps
`include "avg_defines.svh"

module sample_capture (
   input  logic                   clk,
   input  logic                   rstn,
   input  avg_types_pkg::sample_t in_data,
   input  logic                   in_valid,
   sample_fifo_if.writer          fifo,
   output logic                   overflow
);

   import avg_types_pkg::*;

   sample_t hold_data;  // Sample from the previous cycle
   logic    held;

   // The held sample is the last of its burst when in_valid has dropped,
   // so the tag is decided only now, one cycle after the sample arrived
   assign fifo.push    = held && !fifo.full;
   assign fifo.wr_word = '{data: hold_data, last: !in_valid};

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         held     <= 1'b0;
         overflow <= 1'b0;
      end else begin
         held <= in_valid;
         if (held && fifo.full)
            overflow <= 1'b1;  // Sample lost, sticky
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid)
         hold_data <= in_data;
   end

endmodule

//--- logic/sample_fifo.sv
`timescale 1ns/1ps
`include "avg_defines.svh"

module sample_fifo (
   input  logic           clk,
   input  logic           rstn,
   sample_fifo_if.storage fifo
);

   import avg_types_pkg::*;

   localparam int DEPTH = `AVG_FIFO_DEPTH;
   localparam int AW    = $clog2(DEPTH);

   sample_word_t mem [DEPTH];

   // Extra MSB is the wrap bit
   logic [AW:0] wr_ptr;
   logic [AW:0] rd_ptr;
   logic        do_push;
   logic        do_pop;

   assign fifo.empty = (wr_ptr == rd_ptr);
   assign fifo.full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                       (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

   assign do_push = fifo.push && !fifo.full;
   assign do_pop  = fifo.pop && !fifo.empty;

   // First word fall through
   assign fifo.rd_word = mem[rd_ptr[AW-1:0]];

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (do_push)
         mem[wr_ptr[AW-1:0]] <= fifo.wr_word;
   end

endmodule

//--- logic/serial_divider.sv
`timescale 1ns/1ps
`include "avg_defines.svh"

module serial_divider (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  start,
   input  avg_types_pkg::sum_t   dividend,
   input  avg_types_pkg::count_t divisor,
   output avg_types_pkg::sum_t   quotient,
   output logic                  done
);

   import avg_types_pkg::*;
   import avg_ctrl_pkg::*;

   localparam int SW = `AVG_SUM_WIDTH;
   localparam int CW = `AVG_CNT_WIDTH;
   localparam int BW = $clog2(SW);

   div_state_t     state;
   logic [BW-1:0]  bit_cnt;
   sum_t           dvd;      // Dividend bits still to shift in
   count_t         dvs;
   count_t         rem;      // Always below the divisor
   logic [CW:0]    rem_shift;
   logic [CW:0]    diff;
   logic           fits;

   assign rem_shift = {rem, dvd[SW-1]};
   assign fits      = (rem_shift >= {1'b0, dvs});
   assign diff      = rem_shift - {1'b0, dvs};

   assign done = (state == DIV_DONE);

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         state   <= DIV_IDLE;
         bit_cnt <= '0;
      end else begin
         case (state)
            DIV_IDLE: if (start) begin
               state   <= DIV_ITERATE;
               bit_cnt <= '0;
            end
            DIV_ITERATE: begin
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt == BW'(SW - 1))
                  state <= DIV_DONE;
            end
            default: state <= DIV_IDLE;  // DONE lasts one cycle
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == DIV_IDLE && start) begin
         dvd      <= dividend;
         dvs      <= divisor;
         rem      <= '0;
         quotient <= '0;
      end else if (state == DIV_ITERATE) begin
         dvd      <= dvd << 1;
         rem      <= fits ? diff[CW-1:0] : rem_shift[CW-1:0];  // Restore on miss
         quotient <= {quotient[SW-2:0], fits};
      end
   end

endmodule

//--- logic/burst_averager.sv
`timescale 1ns/1ps
`include "avg_defines.svh"

module burst_averager (
   input  logic                   clk,
   input  logic                   rstn,
   sample_fifo_if.reader          fifo,
   output avg_types_pkg::sample_t avg_data,
   output logic                   avg_req,
   input  logic                   avg_ack
);

   import avg_types_pkg::*;
   import avg_ctrl_pkg::*;

   avg_state_t state;
   sum_t       sum;
   count_t     cnt;
   logic       div_start;
   logic       div_done;
   sum_t       quotient;
   logic       taking;

   // Pop only while collecting a burst
   assign taking   = (state == IDLE) || (state == ACCUMULATING);
   assign fifo.pop = taking && !fifo.empty;
   assign avg_req  = (state == OFFER);

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         state     <= IDLE;
         sum       <= '0;
         cnt       <= '0;
         div_start <= 1'b0;
         avg_data  <= '0;
      end else begin
         div_start <= 1'b0;
         case (state)
            IDLE, ACCUMULATING: begin
               if (fifo.pop) begin
                  sum <= sum + sum_t'(fifo.rd_word.data);
                  cnt <= cnt + 1'b1;
                  if (fifo.rd_word.last) begin
                     state     <= DIVIDING;
                     div_start <= 1'b1;  // Sum and count complete next cycle
                  end else begin
                     state <= ACCUMULATING;
                  end
               end
            end
            DIVIDING: begin
               if (div_done) begin
                  avg_data <= quotient[`AVG_WIDTH-1:0];
                  state    <= OFFER;
               end
            end
            OFFER: begin
               if (avg_ack)
                  state <= RELEASE;
            end
            RELEASE: begin
               if (!avg_ack) begin
                  state <= IDLE;
                  sum   <= '0;
                  cnt   <= '0;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   serial_divider i_divider (
      .clk      (clk),
      .rstn     (rstn),
      .start    (div_start),
      .dividend (sum),
      .divisor  (cnt),
      .quotient (quotient),
      .done     (div_done)
   );

endmodule

//--- logic/avg_top.sv
`timescale 1ns/1ps
`include "avg_defines.svh"

module avg_top (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic [`AVG_WIDTH-1:0] in_data,
   input  logic                  in_valid,
   output logic [`AVG_WIDTH-1:0] avg_data,
   output logic                  avg_req,
   input  logic                  avg_ack,
   output logic                  overflow
);

   // Between capture and averager
   sample_fifo_if fifo_bus ();

   sample_capture i_capture (
      .clk      (clk),
      .rstn     (rstn),
      .in_data  (in_data),
      .in_valid (in_valid),
      .fifo     (fifo_bus.writer),
      .overflow (overflow)
   );

   sample_fifo i_fifo (
      .clk  (clk),
      .rstn (rstn),
      .fifo (fifo_bus.storage)
   );

   // Result side with four-phase handshake
   burst_averager i_averager (
      .clk      (clk),
      .rstn     (rstn),
      .fifo     (fifo_bus.reader),
      .avg_data (avg_data),
      .avg_req  (avg_req),
      .avg_ack  (avg_ack)
   );

endmodule

//--- verification/avg_top_tb.sv
`timescale 1ns/1ps
`include "avg_defines.svh"

module avg_top_tb;

   localparam int TIMEOUT = 2000;  // Cycles allowed per wait

   logic                  clk;
   logic                  rstn;
   logic [`AVG_WIDTH-1:0] in_data;
   logic                  in_valid;
   logic [`AVG_WIDTH-1:0] avg_data;
   logic                  avg_req;
   logic                  avg_ack;
   logic                  overflow;

   // Outstanding averages in burst order
   int    exp_q[$];
   string name_q[$];

   int    samples [`AVG_MAX_SAMPLES];
   int    ack_delay [256];
   int    host_phase;
   logic  hold_ack;     // Host ignores avg_req while set
   logic  ovf_armed;
   logic  ovf_latched;
   logic  prev_req;
   logic  [`AVG_WIDTH-1:0] prev_data;

   avg_top i_dut (
      .clk      (clk),
      .rstn     (rstn),
      .in_data  (in_data),
      .in_valid (in_valid),
      .avg_data (avg_data),
      .avg_req  (avg_req),
      .avg_ack  (avg_ack),
      .overflow (overflow)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display(">>> FAIL");
      $fatal(1);
   endtask

   // One burst from samples[] followed by gap idle cycles
   task automatic send_burst(input int len, input int gap);
      int i;
      for (i = 0; i < len; i++) begin
         @(posedge clk);
         in_data  <= `AVG_WIDTH'(samples[i]);
         in_valid <= 1'b1;
      end
      @(posedge clk);
      in_valid <= 1'b0;
      in_data  <= '0;
      repeat (gap - 1) @(posedge clk);
   endtask

   task automatic wait_drained();
      int cnt;
      cnt = 0;
      while (exp_q.size() != 0 || host_phase != 0) begin
         @(negedge clk);
         cnt++;
         assert (cnt < TIMEOUT) else
            stop_with_error("timeout waiting for the outstanding averages");
      end
   endtask

   task automatic wait_for_req();
      int cnt;
      cnt = 0;
      while (!avg_req) begin
         @(negedge clk);
         cnt++;
         assert (cnt < TIMEOUT) else
            stop_with_error("timeout waiting for avg_req to rise");
      end
   endtask

   // Handshake rules and overflow watch
   always @(posedge clk) begin
      if (rstn) begin
         if (avg_req && prev_req)
            assert (avg_data == prev_data) else
               stop_with_error($sformatf("ERROR four_phase: expected %0d, actual %0d",
                                         prev_data, avg_data));
         if (avg_req && !prev_req)
            assert (!avg_ack) else
               stop_with_error("avg_req rose while avg_ack was still high");
         if (!avg_req && prev_req)
            assert (avg_ack) else
               stop_with_error("avg_req dropped before avg_ack was raised");
         if (!ovf_armed)
            assert (!overflow) else
               stop_with_error("overflow went high before the FIFO was overrun");
         if (ovf_latched)
            assert (overflow) else
               stop_with_error("overflow dropped after it had been set");
      end
      prev_req  = avg_req;
      prev_data = avg_data;
   end

   // Host side of the result handshake
   initial begin
      int delay;
      int idx;
      int wait_cnt;
      avg_ack    = 1'b0;
      host_phase = 0;
      idx        = 0;
      delay      = 0;
      wait_cnt   = 0;
      forever begin
         @(posedge clk);
         if (rstn) begin
            case (host_phase)
               0: if (avg_req && !hold_ack) begin
                  assert (exp_q.size() > 0) else
                     stop_with_error("avg_req rose with no burst outstanding");
                  delay      = ack_delay[idx];
                  idx        = (idx + 1) % 256;
                  host_phase = 1;
               end
               1: if (delay > 0) begin
                  delay--;
               end else begin
                  assert (int'(avg_data) == exp_q[0]) else
                     stop_with_error($sformatf("ERROR %s: expected %0d, actual %0d",
                                               name_q[0], exp_q[0], avg_data));
                  $display("checked %s average %0d", name_q[0], exp_q[0]);
                  void'(exp_q.pop_front());
                  void'(name_q.pop_front());
                  avg_ack    <= 1'b1;
                  wait_cnt   = 0;
                  host_phase = 2;
               end
               2: if (!avg_req) begin
                  delay      = ack_delay[idx];
                  idx        = (idx + 1) % 256;
                  host_phase = 3;
               end else begin
                  wait_cnt++;
                  assert (wait_cnt < TIMEOUT) else
                     stop_with_error("timeout waiting for avg_req to drop after avg_ack");
               end
               3: if (delay > 0) begin
                  delay--;
               end else begin
                  avg_ack    <= 1'b0;
                  host_phase = 0;
               end
               default: host_phase = 0;
            endcase
         end
      end
   end

   initial begin
      int    fd;
      int    n;
      int    i;
      int    len;
      int    gap;
      int    fill;
      int    expected;
      int    sum;
      string name;
      string kind;
      string rest;
      void'($urandom(32'h4ea3_2c06));
      foreach (ack_delay[k])
         ack_delay[k] = $urandom % 8;
      rstn        = 1'b0;
      in_data     = '0;
      in_valid    = 1'b0;
      hold_ack    = 1'b0;
      ovf_armed   = 1'b0;
      ovf_latched = 1'b0;
      repeat (16) @(posedge clk);
      rstn <= 1'b1;
      repeat (2) @(posedge clk);

      fd = $fopen("verification/avg_testdata.txt", "r");
      assert (fd != 0) else
         stop_with_error("cannot open verification/avg_testdata.txt");
      while ($fscanf(fd, "%s", name) == 1) begin
         if (name.substr(0, 0) == "#") begin
            void'($fgets(rest, fd));
            continue;
         end
         n = $fscanf(fd, "%d %d %s", len, gap, kind);
         assert (n == 3 && len >= 1 && len <= `AVG_MAX_SAMPLES) else
            stop_with_error($sformatf("bad burst header in test %s", name));
         if (kind == "F") begin
            n = $fscanf(fd, "%d", fill);
            for (i = 0; i < len; i++)
               samples[i] = fill;
         end else begin
            for (i = 0; i < len; i++)
               n = $fscanf(fd, "%d", samples[i]);
         end
         n = $fscanf(fd, "%d", expected);
         assert (n == 1) else
            stop_with_error($sformatf("missing expected average in test %s", name));
         sum = 0;
         for (i = 0; i < len; i++)
            sum += samples[i];
         assert (expected == sum / len) else
            stop_with_error($sformatf("test %s lists %0d, truncated mean is %0d",
                                      name, expected, sum / len));
         exp_q.push_back(expected);
         name_q.push_back(name);
         send_burst(len, (gap > 0) ? gap : 1 + $urandom % 8);
         if (gap == 0)
            wait_drained();
      end
      $fclose(fd);

      // Result left pending so the FIFO cannot drain
      hold_ack <= 1'b1;
      samples[0] = 77;
      exp_q.push_back(77);
      name_q.push_back("overflow_hold");
      send_burst(1, 2);
      wait_for_req();
      ovf_armed <= 1'b1;
      for (i = 0; i < `AVG_FIFO_DEPTH + 8; i++)
         samples[i] = $urandom % 256;
      send_burst(`AVG_FIFO_DEPTH + 8, 2);
      @(negedge clk);
      assert (overflow) else
         stop_with_error("overflow stayed low after the FIFO was overrun");
      ovf_latched <= 1'b1;
      hold_ack    <= 1'b0;
      wait_drained();
      repeat (20) @(posedge clk);  // overflow must hold
      $display(">>> PASS");
      $finish;
   end

endmodule

//--- verification/avg_testdata.txt
# name  length  gap  kind  samples  average   (decimal values)
# kind L lists every sample, F gives one fill value; gap 0 = drain, then random idle
single_7 1 0 L 7 7
single_max 1 0 L 255 255
single_zero 1 0 L 0 0
pair 2 0 L 10 13 11
triple_trunc 3 0 L 1 2 2 1
five_mix 5 0 L 100 200 50 25 90 93
ramp_8 8 0 L 0 1 2 3 4 5 6 7 3
near_max 7 0 L 255 255 255 255 255 255 254 254
zeros_32 32 0 F 0 0
long_max 255 0 F 255 255
long_mid 200 0 F 128 128
b2b_a 3 1 L 9 8 7 8
b2b_b 2 1 L 250 251 250
b2b_c 4 1 L 3 0 0 0 0
b2b_d 3 0 L 60 61 62 61
mix_16 16 0 L 12 200 7 99 150 33 64 250 1 18 77 140 5 222 91 45 88
one_a 1 1 L 11 11
one_b 1 1 L 22 22
one_c 1 1 L 33 33
one_d 1 0 L 44 44
long_a 20 1 F 100 100
long_b 3 0 L 1 1 2 1

//--- verilog.f
+incdir+logic
logic/avg_types_pkg.sv
logic/avg_ctrl_pkg.sv
logic/sample_fifo_if.sv
logic/sample_capture.sv
logic/sample_fifo.sv
logic/serial_divider.sv
logic/burst_averager.sv
logic/avg_top.sv
verification/avg_top_tb.sv

//--- Bender.yml
package:
  name: burst_avg

sources:
  - include_dirs:
      - logic
    files:
      - logic/avg_types_pkg.sv
      - logic/avg_ctrl_pkg.sv
      - logic/sample_fifo_if.sv
      - logic/sample_capture.sv
      - logic/sample_fifo.sv
      - logic/serial_divider.sv
      - logic/burst_averager.sv
      - logic/avg_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - verification/avg_top_tb.sv
